//--- common/rename_pkg.sv
package rename_pkg;

    // register file sizes
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    localparam int ARCH_W = $clog2(NUM_ARCH_REGS);  // 5 bits
    localparam int PHYS_W = $clog2(NUM_PHYS_REGS);  // 6 bits

    // free list holds every physical register but p0, so 64 slots is plenty
    localparam int FREE_DEPTH = NUM_PHYS_REGS;
    localparam int INIT_FREE  = NUM_PHYS_REGS - NUM_ARCH_REGS;  // p32..p63 after reset
    localparam int CNT_W      = $clog2(FREE_DEPTH + 1);         // 0..64 needs 7 bits

    // request from the decoder
    typedef struct packed {
        logic [ARCH_W-1:0] src1;
        logic [ARCH_W-1:0] src2;
        logic [ARCH_W-1:0] dest;
    } arch_regs_t;

    // rename result, dest_old goes to the ROB for freeing at commit
    typedef struct packed {
        logic [PHYS_W-1:0] src1;
        logic [PHYS_W-1:0] src2;
        logic [PHYS_W-1:0] dest;
        logic [PHYS_W-1:0] dest_old;
    } phys_regs_t;

    // map table read results, all taken before this cycle's write
    typedef struct packed {
        logic [PHYS_W-1:0] src1;
        logic [PHYS_W-1:0] src2;
        logic [PHYS_W-1:0] dest_old;
    } map_lookup_t;

endpackage

//--- rename/rename_ctrl.sv
module rename_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         rename_en,
    input  rename_pkg::arch_regs_t       arch_in,
    input  logic                         commit_en,
    input  logic [rename_pkg::PHYS_W-1:0] commit_phys,
    input  rename_pkg::map_lookup_t      lookup,
    input  logic [rename_pkg::PHYS_W-1:0] head_reg,
    input  logic                         empty,
    output logic                         map_we,
    output logic [rename_pkg::ARCH_W-1:0] map_waddr,
    output logic [rename_pkg::PHYS_W-1:0] map_wdata,
    output logic                         pop,
    output logic                         push,
    output logic [rename_pkg::PHYS_W-1:0] push_reg,
    output logic                         stall,
    output logic                         out_valid,
    output rename_pkg::phys_regs_t       phys_out
);
    import rename_pkg::*;

    logic       dest_nz;   // destination is not r0
    logic       accept;
    logic       alloc;
    phys_regs_t result;

    assign dest_nz = (arch_in.dest != '0);

    // no free register left: hold the instruction in the decoder
    assign stall  = rename_en && dest_nz && empty;
    assign accept = rename_en && !stall;
    assign alloc  = accept && dest_nz;  // r0 never takes a register

    // new mapping goes in at the edge, lookups this cycle still see the old one
    assign map_we    = alloc;
    assign map_waddr = arch_in.dest;
    assign map_wdata = head_reg;
    assign pop       = alloc;

    // commits of p0 are dropped, p0 is never in the free list
    assign push     = commit_en && (commit_phys != '0);
    assign push_reg = commit_phys;

    always_comb begin
        result.src1 = lookup.src1;
        result.src2 = lookup.src2;
        if (dest_nz) begin
            result.dest     = head_reg;
            result.dest_old = lookup.dest_old;
        end else begin
            result.dest     = '0;
            result.dest_old = '0;   // nothing to free at commit
        end
    end

    // output register, one cycle from rename_en
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            phys_out <= result;
        end
    end

endmodule

//--- rename/map_table.sv
module map_table (
    input  logic                          clk,
    input  logic                          reset,
    input  rename_pkg::arch_regs_t        rd_arch,
    output rename_pkg::map_lookup_t       lookup,
    input  logic                          we,
    input  logic [rename_pkg::ARCH_W-1:0] waddr,
    input  logic [rename_pkg::PHYS_W-1:0] wdata
);
    import rename_pkg::*;

    // one physical index per architectural register
    logic [PHYS_W-1:0] map [NUM_ARCH_REGS];

    // combinational reads, the write below lands only at the edge
    assign lookup.src1     = map[rd_arch.src1];
    assign lookup.src2     = map[rd_arch.src2];
    assign lookup.dest_old = map[rd_arch.dest];

    always_ff @(posedge clk) begin
        if (reset) begin
            // identity map, ri -> pi
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map[i] <= PHYS_W'(i);
            end
        end else if (we) begin
            map[waddr] <= wdata;
        end
    end

endmodule

//--- rename/free_list.sv
module free_list (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pop,
    input  logic                          push,
    input  logic [rename_pkg::PHYS_W-1:0] push_reg,
    output logic [rename_pkg::PHYS_W-1:0] head_reg,
    output logic                          empty,
    output logic [rename_pkg::CNT_W-1:0]  count
);
    import rename_pkg::*;

    logic [PHYS_W-1:0]                 fifo [FREE_DEPTH];
    logic [$clog2(FREE_DEPTH)-1:0]     head;   // next register to hand out
    logic [$clog2(FREE_DEPTH)-1:0]     tail;   // next slot for a returned register
    logic [CNT_W-1:0]                  occ;

    assign head_reg = fifo[head];
    assign empty    = (occ == '0);
    assign count    = occ;

    // buffer storage
    always_ff @(posedge clk) begin
        if (reset) begin
            // p32..p63 in order, rest of the slots cleared
            for (int i = 0; i < FREE_DEPTH; i++) begin
                if (i < INIT_FREE) begin
                    fifo[i] <= PHYS_W'(i + NUM_ARCH_REGS);
                end else begin
                    fifo[i] <= '0;
                end
            end
        end else if (push) begin
            fifo[tail] <= push_reg;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= ($clog2(FREE_DEPTH))'(INIT_FREE);
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // occupancy, push and pop together leave it unchanged
    always_ff @(posedge clk) begin
        if (reset) begin
            occ <= CNT_W'(INIT_FREE);
        end else begin
            occ <= occ + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

//--- design/rename_top.sv
module rename_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rename_en,
    input  rename_pkg::arch_regs_t        arch_in,
    input  logic                          commit_en,
    input  logic [rename_pkg::PHYS_W-1:0] commit_phys,
    output logic                          out_valid,
    output rename_pkg::phys_regs_t        phys_out,
    output logic                          stall,
    output logic [rename_pkg::CNT_W-1:0]  free_count
);
    import rename_pkg::*;

    map_lookup_t       lookup;
    logic              map_we;
    logic [ARCH_W-1:0] map_waddr;
    logic [PHYS_W-1:0] map_wdata;
    logic              pop;
    logic              push;
    logic [PHYS_W-1:0] push_reg;
    logic [PHYS_W-1:0] head_reg;   // register offered for the next allocation
    logic              empty;

    rename_ctrl i_ctrl (
        .clk         (clk),
        .reset       (reset),
        .rename_en   (rename_en),
        .arch_in     (arch_in),
        .commit_en   (commit_en),
        .commit_phys (commit_phys),
        .lookup      (lookup),
        .head_reg    (head_reg),
        .empty       (empty),
        .map_we      (map_we),
        .map_waddr   (map_waddr),
        .map_wdata   (map_wdata),
        .pop         (pop),
        .push        (push),
        .push_reg    (push_reg),
        .stall       (stall),
        .out_valid   (out_valid),
        .phys_out    (phys_out)
    );

    map_table i_map (
        .clk     (clk),
        .reset   (reset),
        .rd_arch (arch_in),
        .lookup  (lookup),
        .we      (map_we),
        .waddr   (map_waddr),
        .wdata   (map_wdata)
    );

    free_list i_free (
        .clk      (clk),
        .reset    (reset),
        .pop      (pop),
        .push     (push),
        .push_reg (push_reg),
        .head_reg (head_reg),
        .empty    (empty),
        .count    (free_count)
    );

endmodule

//--- verif/rename_tests.svh
`ifndef RENAME_TESTS_SVH
`define RENAME_TESTS_SVH

// identity map right after reset
task automatic lookup_after_reset();
    apply_reset();
    rename_op(3, 7, 0);
    rename_op(31, 1, 0);
    check_eq("src1 of r3", int'(phys_out.src1), 3);
    check_eq("src2 of r7", int'(phys_out.src2), 7);
    idle_op();
    check_eq("src1 of r31", int'(phys_out.src1), 31);
    check_eq("src2 of r1", int'(phys_out.src2), 1);
    check_eq("free_count", int'(free_count), 32);
    check_eq("stall", int'(stall), 0);
    report_test("lookup_after_reset");
endtask

// back to back renames where each sees the mapping of the one before
task automatic alloc_in_order();
    apply_reset();
    rename_op(1, 2, 5);
    rename_op(5, 0, 6);
    check_eq("out_valid", int'(out_valid), 1);
    check_eq("first dest", int'(phys_out.dest), 32);
    check_eq("first dest_old", int'(phys_out.dest_old), 5);
    rename_op(6, 5, 5);
    check_eq("r5 after rename", int'(phys_out.src1), 32);
    check_eq("second dest", int'(phys_out.dest), 33);
    check_eq("second dest_old", int'(phys_out.dest_old), 6);
    idle_op();
    check_eq("r6 after rename", int'(phys_out.src1), 33);
    check_eq("r5 as src2", int'(phys_out.src2), 32);
    check_eq("third dest", int'(phys_out.dest), 34);
    check_eq("third dest_old", int'(phys_out.dest_old), 32);
    check_eq("free_count", int'(free_count), 29);
    idle_op();
    check_eq("out_valid when idle", int'(out_valid), 0);
    report_test("alloc_in_order");
endtask

task automatic zero_dest_no_alloc();
    apply_reset();
    rename_op(1, 0, 4);
    rename_op(4, 0, 0);
    check_eq("r4 dest", int'(phys_out.dest), 32);
    idle_op();
    check_eq("zero dest", int'(phys_out.dest), 0);
    check_eq("zero dest_old", int'(phys_out.dest_old), 0);
    check_eq("r4 as src1", int'(phys_out.src1), 32);
    check_eq("r0 as src2", int'(phys_out.src2), 0);
    check_eq("free_count", int'(free_count), 31);
    rename_op(0, 4, 0);
    idle_op();
    check_eq("r0 unchanged", int'(phys_out.src1), 0);
    check_eq("r4 unchanged", int'(phys_out.src2), 32);
    check_eq("free_count", int'(free_count), 31);
    report_test("zero_dest_no_alloc");
endtask

// drain the free list until a rename stalls and return one register
task automatic exhaust_and_refill();
    apply_reset();
    for (int i = 0; i < INIT_FREE; i++) begin
        rename_op(0, 0, (i % 31) + 1);
    end
    idle_op();
    check_eq("free_count when drained", int'(free_count), 0);
    check_eq("last dest", int'(phys_out.dest), 63);
    check_eq("last dest_old", int'(phys_out.dest_old), 32);
    drive_cycle(1, 0, 0, 9, 0, 0);
    check_eq("stall when empty", int'(stall), 1);
    drive_cycle(1, 0, 0, 9, 1, 1);  // commit in the same cycle does not help yet
    check_eq("out_valid on refused rename", int'(out_valid), 0);
    check_eq("stall with same cycle commit", int'(stall), 1);
    idle_op();
    check_eq("free_count after commit", int'(free_count), 1);
    rename_op(0, 0, 9);
    check_eq("stall after refill", int'(stall), 0);
    idle_op();
    check_eq("out_valid after refill", int'(out_valid), 1);
    check_eq("returned register", int'(phys_out.dest), 1);
    check_eq("r9 dest_old", int'(phys_out.dest_old), 40);
    check_eq("free_count", int'(free_count), 0);
    commit_op(0);
    idle_op();
    check_eq("free_count after p0 commit", int'(free_count), 0);
    report_test("exhaust_and_refill");
endtask

// renames mixed with in-order commits of earlier dest_old values
task automatic random_mix();
    int r;
    int ren;
    int cen;
    int cphys;
    int pending [$];
    apply_reset();
    for (int n = 0; n < 800; n++) begin
        r     = $random(seed);
        ren   = ((r & 3) != 0) ? 1 : 0;           // about 3 of 4 cycles
        cen   = (((r >> 17) & 7) < 5 && pending.size() > 0) ? 1 : 0;
        cphys = (cen != 0) ? pending.pop_front() : 0;
        drive_cycle(ren, (r >> 2) & 31, (r >> 7) & 31, (r >> 12) & 31, cen, cphys);
        if (exp_valid && exp_out.dest != '0) begin
            pending.push_back(int'(exp_out.dest_old));
        end
    end
    idle_op();
    idle_op();
    report_test("random_mix");
endtask

`endif

//--- verif/rename_tb.sv
module rename_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import rename_pkg::*;

    localparam int MAX_CYCLES = 3000;  // tests need about 1200 at most

    logic              clk = 1'b0;
    logic              reset;
    logic              rename_en;
    arch_regs_t        arch_in;
    logic              commit_en;
    logic [PHYS_W-1:0] commit_phys;
    logic              out_valid;
    phys_regs_t        phys_out;
    logic              stall;
    logic [CNT_W-1:0]  free_count;

    // reference model: map, free list and the result due next cycle
    logic [PHYS_W-1:0] ref_map [NUM_ARCH_REGS];
    logic [PHYS_W-1:0] ref_free [$];
    logic              exp_valid;
    phys_regs_t        exp_out;

    int seed        = 69;
    int cycle_count = 0;
    int checks      = 0;
    int errors      = 0;
    int test_errors = 0;
    int tests_run   = 0;

    rename_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .rename_en   (rename_en),
        .arch_in     (arch_in),
        .commit_en   (commit_en),
        .commit_phys (commit_phys),
        .out_valid   (out_valid),
        .phys_out    (phys_out),
        .stall       (stall),
        .free_count  (free_count)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_eq(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("%-20s %0d wrong", name, test_errors);
        tests_run++;
        test_errors = 0;
    endtask

    // reset for 5 cycles, then both DUT and model start from the identity map
    task automatic apply_reset();
        @(posedge clk);
        reset       <= 1'b1;
        rename_en   <= 1'b0;
        commit_en   <= 1'b0;
        arch_in     <= '0;
        commit_phys <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            ref_map[i] = PHYS_W'(i);
        end
        ref_free.delete();
        for (int i = NUM_ARCH_REGS; i < NUM_PHYS_REGS; i++) begin
            ref_free.push_back(PHYS_W'(i));
        end
        exp_valid = 1'b0;
        @(negedge clk);
        check_eq("out_valid after reset", int'(out_valid), 0);
        check_eq("stall after reset", int'(stall), 0);
        check_eq("free_count after reset", int'(free_count), INIT_FREE);
    endtask

    // one clock of stimulus, checked against the model at the falling edge
    task automatic drive_cycle(input int ren, input int s1, input int s2, input int d,
                               input int cen, input int cphys);
        logic exp_stall;
        logic alloc;
        @(posedge clk);
        rename_en    <= (ren != 0);
        arch_in.src1 <= ARCH_W'(s1);
        arch_in.src2 <= ARCH_W'(s2);
        arch_in.dest <= ARCH_W'(d);
        commit_en    <= (cen != 0);
        commit_phys  <= PHYS_W'(cphys);
        @(negedge clk);
        // registered result of the previous cycle
        check_eq("out_valid", int'(out_valid), int'(exp_valid));
        if (exp_valid) begin
            check_eq("phys_out.src1", int'(phys_out.src1), int'(exp_out.src1));
            check_eq("phys_out.src2", int'(phys_out.src2), int'(exp_out.src2));
            check_eq("phys_out.dest", int'(phys_out.dest), int'(exp_out.dest));
            check_eq("phys_out.dest_old", int'(phys_out.dest_old), int'(exp_out.dest_old));
        end
        check_eq("free_count", int'(free_count), ref_free.size());
        exp_stall = (ren != 0) && (d != 0) && (ref_free.size() == 0);
        check_eq("stall", int'(stall), int'(exp_stall));
        exp_valid = (ren != 0) && !exp_stall;
        alloc     = exp_valid && (d != 0);
        if (exp_valid) begin
            exp_out.src1     = ref_map[s1];
            exp_out.src2     = ref_map[s2];
            exp_out.dest     = alloc ? ref_free[0] : '0;
            exp_out.dest_old = alloc ? ref_map[d] : '0;
        end
        if (alloc) begin
            ref_map[d] = ref_free.pop_front();
        end
        if ((cen != 0) && (cphys != 0)) begin
            ref_free.push_back(PHYS_W'(cphys));  // usable from the next cycle on
        end
    endtask

    task automatic rename_op(input int s1, input int s2, input int d);
        drive_cycle(1, s1, s2, d, 0, 0);
    endtask

    task automatic commit_op(input int p);
        drive_cycle(0, 0, 0, 0, 1, p);
    endtask

    task automatic idle_op();
        drive_cycle(0, 0, 0, 0, 0, 0);
    endtask

    `include "rename_tests.svh"

    initial begin
        reset       = 1'b1;
        rename_en   = 1'b0;
        arch_in     = '0;
        commit_en   = 1'b0;
        commit_phys = '0;
        exp_valid   = 1'b0;
        exp_out     = '0;
        lookup_after_reset();
        alloc_in_order();
        zero_dest_no_alloc();
        exhaust_and_refill();
        random_mix();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- files.f
common/rename_pkg.sv
rename/rename_ctrl.sv
rename/map_table.sv
rename/free_list.sv
design/rename_top.sv
+incdir+verif
verif/rename_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = rename_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
